//--- Makefile
SIM = obj_dir/Vtb_neuron_axil_top

all: run

$(SIM): neuron_axil_top.f $(shell cat neuron_axil_top.f)
	verilator --binary --timing --assert -Wno-fatal -f neuron_axil_top.f \
		--top-module tb_neuron_axil_top

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- bench/tb_neuron_axil_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_neuron_axil_top
    import nn_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20;

    logic  clk_i;
    logic  rst_i;
    addr_t awaddr_i;
    logic  awvalid_i;
    logic  awready_o;
    data_t wdata_i;
    logic  wvalid_i;
    logic  wready_o;
    resp_t bresp_o;
    logic  bvalid_o;
    logic  bready_i;
    addr_t araddr_i;
    logic  arvalid_i;
    logic  arready_o;
    data_t rdata_o;
    resp_t rresp_o;
    logic  rvalid_o;
    logic  rready_i;

    int mismatches = 0;
    int other_errs = 0;
    // lcg state, seed 1
    data_t lcg_state = 32'd1;

    // operands as last loaded into the dut
    act_t    x_val [N_INPUTS];
    weight_t w_val [N_INPUTS];
    target_t t_val;
    // running accumulator and count
    acc_t    acc_model = '0;
    count_t  count_model = '0;

    neuron_axil_top neuron_axil_top_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .awaddr_i  (awaddr_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .araddr_i  (araddr_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i)
    );

    // 100 ns period
    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic data_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // sum of products, then difference wrapped at 23 bits, squared into 46 bits
    function automatic neuron_result_t model_eval();
        logic [63:0]    total;
        logic [63:0]    diff;
        neuron_result_t res;
        total = '0;
        for (int i = 0; i < N_INPUTS; i++) begin
            total = total + 64'(x_val[i]) * 64'(w_val[i]);
        end
        diff = (total - 64'(t_val)) & ((64'd1 << 23) - 64'd1);
        res.sum = sum_t'(total);
        res.loss = loss_t'(diff * diff);
        return res;
    endfunction

    // saturates at all ones, count wraps
    task automatic model_accumulate(input loss_t loss);
        logic [48:0] total;
        total = 49'(acc_model) + 49'(loss);
        acc_model = total[48] ? '1 : total[47:0];
        count_model = count_model + 16'd1;
    endtask

    task automatic check_sum(input string name, input sum_t got, input sum_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_loss(input string name, input loss_t got, input loss_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_acc(input string name, input acc_t got, input acc_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_word(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_resp(input string name, input resp_t got, input resp_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    // drive on rising edge, sample on falling edge
    task automatic axil_write(input addr_t addr, input data_t data, input int bready_delay,
                              output resp_t resp);
        int    cnt;
        resp_t first;
        @(posedge clk_i);
        awaddr_i  <= addr;
        awvalid_i <= 1'b1;
        wdata_i   <= data;
        wvalid_i  <= 1'b1;
        bready_i  <= (bready_delay == 0);
        cnt = 0;
        do begin
            @(negedge clk_i);
            cnt++;
            // aw and w ready move together
            if (wready_o !== awready_o) begin
                $display("wready_o and awready_o differ at write to 0x%h", addr);
                other_errs++;
            end
        end while (!awready_o && cnt < TIMEOUT_CYCLES);
        if (!awready_o) begin
            $display("timeout: write to 0x%h was never accepted", addr);
            other_errs++;
        end
        @(posedge clk_i);
        awvalid_i <= 1'b0;
        wvalid_i  <= 1'b0;
        // b must hold with a steady code while bready is low
        for (int k = 0; k < bready_delay; k++) begin
            @(negedge clk_i);
            if (!bvalid_o) begin
                $display("bvalid dropped before bready at write to 0x%h", addr);
                other_errs++;
            end
            if (k == 0) begin
                first = bresp_o;
            end else begin
                check_resp("bresp_o (held)", bresp_o, first);
            end
        end
        if (bready_delay > 0) begin
            @(posedge clk_i);
            bready_i <= 1'b1;
        end
        cnt = 0;
        do begin
            @(negedge clk_i);
            cnt++;
        end while (!bvalid_o && cnt < TIMEOUT_CYCLES);
        if (!bvalid_o) begin
            $display("timeout: no write response for 0x%h", addr);
            other_errs++;
        end
        resp = bresp_o;
        @(posedge clk_i);
        bready_i <= 1'b0;
    endtask

    task automatic axil_read(input addr_t addr, input int rready_delay,
                             output data_t data, output resp_t resp);
        int    cnt;
        data_t first_data;
        resp_t first_resp;
        @(posedge clk_i);
        araddr_i  <= addr;
        arvalid_i <= 1'b1;
        rready_i  <= (rready_delay == 0);
        cnt = 0;
        do begin
            @(negedge clk_i);
            cnt++;
        end while (!arready_o && cnt < TIMEOUT_CYCLES);
        if (!arready_o) begin
            $display("timeout: read of 0x%h was never accepted", addr);
            other_errs++;
        end
        @(posedge clk_i);
        arvalid_i <= 1'b0;
        // r data and code frozen until rready
        for (int k = 0; k < rready_delay; k++) begin
            @(negedge clk_i);
            if (!rvalid_o) begin
                $display("rvalid dropped before rready at read of 0x%h", addr);
                other_errs++;
            end
            if (k == 0) begin
                first_data = rdata_o;
                first_resp = rresp_o;
            end else begin
                check_word("rdata_o (held)", rdata_o, first_data);
                check_resp("rresp_o (held)", rresp_o, first_resp);
            end
        end
        if (rready_delay > 0) begin
            @(posedge clk_i);
            rready_i <= 1'b1;
        end
        cnt = 0;
        do begin
            @(negedge clk_i);
            cnt++;
        end while (!rvalid_o && cnt < TIMEOUT_CYCLES);
        if (!rvalid_o) begin
            $display("timeout: no read data for 0x%h", addr);
            other_errs++;
        end
        data = rdata_o;
        resp = rresp_o;
        @(posedge clk_i);
        rready_i <= 1'b0;
    endtask

    task automatic write_reg(input addr_t addr, input data_t data);
        resp_t resp;
        axil_write(addr, data, 0, resp);
        check_resp($sformatf("bresp_o at 0x%h", addr), resp, RESP_OKAY);
    endtask

    task automatic read_reg(input addr_t addr, output data_t data);
        resp_t resp;
        axil_read(addr, 0, data, resp);
        check_resp($sformatf("rresp_o at 0x%h", addr), resp, RESP_OKAY);
    endtask

    task automatic expect_reg(input addr_t addr, input data_t exp);
        data_t word;
        read_reg(addr, word);
        check_word($sformatf("rdata_o at 0x%h", addr), word, exp);
    endtask

    // poll status bit 0
    task automatic wait_done();
        data_t word;
        resp_t resp;
        int    polls;
        polls = 0;
        do begin
            axil_read(ADDR_STATUS, 0, word, resp);
            polls++;
        end while (!word[0] && polls < TIMEOUT_CYCLES);
        if (!word[0]) begin
            $display("timeout: done flag never set");
            other_errs++;
        end
    endtask

    task automatic load_operands();
        for (int i = 0; i < N_INPUTS; i++) begin
            write_reg(addr_t'(ADDR_X0 + 4 * i), data_t'(x_val[i]));
            write_reg(addr_t'(ADDR_W0 + 4 * i), data_t'(w_val[i]));
        end
        write_reg(ADDR_TARGET, data_t'(t_val));
    endtask

    // one evaluation, results checked against the running model
    task automatic run_eval();
        neuron_result_t exp;
        data_t          lo;
        data_t          hi;
        load_operands();
        write_reg(ADDR_CTRL, 32'h1);
        wait_done();
        exp = model_eval();
        model_accumulate(exp.loss);
        read_reg(ADDR_SUM, lo);
        check_sum("SUM", sum_t'(lo), exp.sum);
        read_reg(ADDR_LOSS_LO, lo);
        read_reg(ADDR_LOSS_HI, hi);
        check_loss("LOSS", loss_t'({hi, lo}), exp.loss);
        read_reg(ADDR_ACC_LO, lo);
        read_reg(ADDR_ACC_HI, hi);
        check_acc("ACC", acc_t'({hi, lo}), acc_model);
        expect_reg(ADDR_COUNT, data_t'(count_model));
    endtask

    task automatic test_register_readback();
        data_t pattern;
        for (int i = 0; i < N_INPUTS; i++) begin
            write_reg(addr_t'(ADDR_X0 + 4 * i), 32'hFFFF_FFFF);
            expect_reg(addr_t'(ADDR_X0 + 4 * i), 32'h0000_03FF);
            pattern = lcg_next();
            write_reg(addr_t'(ADDR_X0 + 4 * i), pattern);
            expect_reg(addr_t'(ADDR_X0 + 4 * i), pattern & 32'h0000_03FF);
            write_reg(addr_t'(ADDR_W0 + 4 * i), 32'hFFFF_FFFF);
            expect_reg(addr_t'(ADDR_W0 + 4 * i), 32'h0000_00FF);
            pattern = lcg_next();
            write_reg(addr_t'(ADDR_W0 + 4 * i), pattern);
            expect_reg(addr_t'(ADDR_W0 + 4 * i), pattern & 32'h0000_00FF);
        end
        write_reg(ADDR_TARGET, 32'hFFFF_FFFF);
        expect_reg(ADDR_TARGET, 32'h0000_000F);
        pattern = lcg_next();
        write_reg(ADDR_TARGET, pattern);
        expect_reg(ADDR_TARGET, pattern & 32'h0000_000F);
        // upper bits only, no start, no clear
        write_reg(ADDR_CTRL, 32'hFFFF_FFFC);
        expect_reg(ADDR_CTRL, 32'h0);
    endtask

    task automatic test_single_eval();
        for (int i = 0; i < N_INPUTS; i++) begin
            x_val[i] = act_t'(100 * (i + 1));
            w_val[i] = weight_t'(30 + 17 * i);
        end
        t_val = 4'd3;
        run_eval();
        expect_reg(ADDR_COUNT, 32'h1);
    endtask

    task automatic test_wrapped_difference();
        loss_t exp;
        data_t lo;
        data_t hi;
        for (int i = 0; i < N_INPUTS; i++) begin
            x_val[i] = '0;
            w_val[i] = weight_t'(8'hC0 + i);
        end
        t_val = 4'd5;
        run_eval();
        // (2^23 - 5) squared, still below 2^46
        exp = loss_t'(((64'd1 << 23) - 64'd5) * ((64'd1 << 23) - 64'd5));
        read_reg(ADDR_LOSS_LO, lo);
        read_reg(ADDR_LOSS_HI, hi);
        check_loss("LOSS (wrapped)", loss_t'({hi, lo}), exp);
    endtask

    task automatic test_random_accumulate();
        neuron_result_t last;
        for (int run = 0; run < 10; run++) begin
            for (int i = 0; i < N_INPUTS; i++) begin
                x_val[i] = act_t'(lcg_next() >> 16);
                w_val[i] = weight_t'(lcg_next() >> 16);
            end
            t_val = target_t'(lcg_next() >> 16);
            run_eval();
        end
        last = model_eval();
        write_reg(ADDR_CTRL, 32'h2);
        acc_model = '0;
        count_model = '0;
        expect_reg(ADDR_ACC_LO, 32'h0);
        expect_reg(ADDR_ACC_HI, 32'h0);
        expect_reg(ADDR_COUNT, 32'h0);
        // last result survives the clear
        expect_reg(ADDR_SUM, data_t'(last.sum));
    endtask

    task automatic test_errors_backpressure();
        data_t word;
        resp_t resp;
        write_reg(ADDR_TARGET, 32'h9);
        axil_write(8'h64, 32'hFFFF_FFFF, 0, resp);
        check_resp("bresp_o at 0x64", resp, RESP_SLVERR);
        axil_write(8'h42, 32'h0000_0003, 0, resp);
        check_resp("bresp_o at 0x42", resp, RESP_SLVERR);
        axil_read(8'h64, 0, word, resp);
        check_resp("rresp_o at 0x64", resp, RESP_SLVERR);
        axil_read(8'h42, 0, word, resp);
        check_resp("rresp_o at 0x42", resp, RESP_SLVERR);
        // unaligned write next to target left it alone
        expect_reg(ADDR_TARGET, 32'h9);
        // slow bready and rready
        axil_write(addr_t'(ADDR_W0 + 4), 32'h0000_005A, 4, resp);
        check_resp("bresp_o slow", resp, RESP_OKAY);
        axil_read(addr_t'(ADDR_W0 + 4), 4, word, resp);
        check_word("rdata_o slow", word, 32'h0000_005A);
        check_resp("rresp_o slow", resp, RESP_OKAY);
        axil_write(8'h64, 32'h0, 4, resp);
        check_resp("bresp_o slow at 0x64", resp, RESP_SLVERR);
        axil_read(8'h42, 4, word, resp);
        check_resp("rresp_o slow at 0x42", resp, RESP_SLVERR);
    endtask

    initial begin
        rst_i     <= 1'b0;
        awaddr_i  <= '0;
        awvalid_i <= 1'b0;
        wdata_i   <= '0;
        wvalid_i  <= 1'b0;
        bready_i  <= 1'b0;
        araddr_i  <= '0;
        arvalid_i <= 1'b0;
        rready_i  <= 1'b0;
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b1;
        test_register_readback();
        test_single_eval();
        test_wrapped_difference();
        test_random_accumulate();
        test_errors_backpressure();
        repeat (2) @(posedge clk_i);
        $display("mismatches: %0d, other failures: %0d", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- neuron_axil_top.f
rtl/nn_pkg.sv
rtl/axil_reg_decode.sv
rtl/output_neuron.sv
rtl/loss_result.sv
rtl/neuron_axil_top.sv
bench/tb_neuron_axil_top.sv

//--- rtl/axil_reg_decode.sv
`timescale 1ns/10ps
`default_nettype none

module axil_reg_decode
    import nn_pkg::*;
(
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    // write address and data
    input  wire addr_t            awaddr_i,
    input  wire logic             awvalid_i,
    output logic                  awready_o,
    input  wire data_t            wdata_i,
    input  wire logic             wvalid_i,
    output logic                  wready_o,
    // write response
    output resp_t                 bresp_o,
    output logic                  bvalid_o,
    input  wire logic             bready_i,
    // read address and data
    input  wire addr_t            araddr_i,
    input  wire logic             arvalid_i,
    output logic                  arready_o,
    output data_t                 rdata_o,
    output resp_t                 rresp_o,
    output logic                  rvalid_o,
    input  wire logic             rready_i,
    // neuron side
    output neuron_operands_t      operands_o,
    output logic                  start_o,
    output logic                  clear_o,
    input  wire result_status_t   status_i
);

    neuron_operands_t ops_q;
    logic             wr_hs;
    logic             rd_hs;
    logic             wr_err;
    logic             rd_err;
    data_t            rd_mux;

    // aw and w accepted together, only with no b pending
    assign wr_hs     = awvalid_i && wvalid_i && !bvalid_o;
    assign awready_o = wr_hs;
    assign wready_o  = wr_hs;

    // one outstanding read at a time
    assign rd_hs     = arvalid_i && !rvalid_o;
    assign arready_o = !rvalid_o;

    // past the last register or not word aligned
    assign wr_err = (awaddr_i > ADDR_COUNT) || (awaddr_i[1:0] != 2'b00);
    assign rd_err = (araddr_i > ADDR_COUNT) || (araddr_i[1:0] != 2'b00);

    assign operands_o = ops_q;

    // write side: operand regs, ctrl pulses, b channel
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            ops_q    <= '0;
            start_o  <= 1'b0;
            clear_o  <= 1'b0;
            bvalid_o <= 1'b0;
            bresp_o  <= RESP_OKAY;
        end else begin
            // pulses last one cycle only
            start_o <= 1'b0;
            clear_o <= 1'b0;
            if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (wr_hs) begin
                bvalid_o <= 1'b1;
                bresp_o  <= wr_err ? RESP_SLVERR : RESP_OKAY;
                if (!wr_err) begin
                    // x bank, then w bank, index from addr[4:2]
                    if (awaddr_i[7:5] == ADDR_X0[7:5]) begin
                        ops_q.x[awaddr_i[4:2]] <= act_t'(wdata_i);
                    end else if (awaddr_i[7:5] == ADDR_W0[7:5]) begin
                        ops_q.w[awaddr_i[4:2]] <= weight_t'(wdata_i);
                    end else if (awaddr_i == ADDR_TARGET) begin
                        ops_q.target <= target_t'(wdata_i);
                    end else if (awaddr_i == ADDR_CTRL) begin
                        start_o <= wdata_i[0];
                        clear_o <= wdata_i[1];
                    end
                    // status and result regs silently drop writes
                end
            end
        end
    end

    // read mux, unused upper bits zero
    always_comb begin
        rd_mux = '0;
        if (araddr_i[7:5] == ADDR_X0[7:5]) begin
            rd_mux = data_t'(ops_q.x[araddr_i[4:2]]);
        end else if (araddr_i[7:5] == ADDR_W0[7:5]) begin
            rd_mux = data_t'(ops_q.w[araddr_i[4:2]]);
        end else begin
            case (araddr_i)
                ADDR_TARGET:  rd_mux = data_t'(ops_q.target);
                // ctrl is write-only
                ADDR_CTRL:    rd_mux = '0;
                ADDR_STATUS:  rd_mux = data_t'(status_i.done);
                ADDR_SUM:     rd_mux = data_t'(status_i.last.sum);
                ADDR_LOSS_LO: rd_mux = status_i.last.loss[31:0];
                ADDR_LOSS_HI: rd_mux = data_t'(status_i.last.loss[45:32]);
                ADDR_ACC_LO:  rd_mux = status_i.loss_acc[31:0];
                ADDR_ACC_HI:  rd_mux = data_t'(status_i.loss_acc[47:32]);
                ADDR_COUNT:   rd_mux = data_t'(status_i.eval_count);
                default:      rd_mux = '0;
            endcase
        end
    end

    // r channel, data held until rready
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            rvalid_o <= 1'b0;
            rdata_o  <= '0;
            rresp_o  <= RESP_OKAY;
        end else if (rd_hs) begin
            rvalid_o <= 1'b1;
            rdata_o  <= rd_err ? '0 : rd_mux;
            rresp_o  <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end else if (rvalid_o && rready_i) begin
            rvalid_o <= 1'b0;
        end
    end

    // response held with stable code until taken
    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

    a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

endmodule

`default_nettype wire

//--- rtl/loss_result.sv
`timescale 1ns/10ps
`default_nettype none

module loss_result
    import nn_pkg::*;
(
    input  wire logic           clk_i,
    input  wire logic           rst_i,
    input  wire logic           result_valid_i,
    input  wire neuron_result_t result_i,
    input  wire logic           start_i,
    input  wire logic           clear_i,
    output result_status_t      status_o
);

    // one spare bit to catch the carry out
    logic [$bits(acc_t):0] acc_sum;

    assign acc_sum = {1'b0, status_o.loss_acc} + ($bits(acc_t) + 1)'(result_i.loss);

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            status_o <= '0;
        end else begin
            // last result survives a clear
            if (result_valid_i) begin
                status_o.last <= result_i;
                status_o.done <= 1'b1;
            end
            // a new start wins, another evaluation is in flight
            if (start_i) begin
                status_o.done <= 1'b0;
            end
            // clear beats a same-cycle result
            if (clear_i) begin
                status_o.loss_acc   <= '0;
                status_o.eval_count <= '0;
            end else if (result_valid_i) begin
                // pin at all ones on overflow
                if (acc_sum[$bits(acc_t)]) begin
                    status_o.loss_acc <= '1;
                end else begin
                    status_o.loss_acc <= acc_sum[$bits(acc_t)-1:0];
                end
                // count just wraps
                status_o.eval_count <= status_o.eval_count + 1'b1;
            end
        end
    end

    // count only moves on a result or a clear
    a_count_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        !result_valid_i && !clear_i |=> $stable(status_o.eval_count));

endmodule

`default_nettype wire

//--- rtl/neuron_axil_top.sv
`timescale 1ns/10ps
`default_nettype none

module neuron_axil_top
    import nn_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_i,
    // write channels
    input  wire addr_t awaddr_i,
    input  wire logic  awvalid_i,
    output logic       awready_o,
    input  wire data_t wdata_i,
    input  wire logic  wvalid_i,
    output logic       wready_o,
    output resp_t      bresp_o,
    output logic       bvalid_o,
    input  wire logic  bready_i,
    // read channels
    input  wire addr_t araddr_i,
    input  wire logic  arvalid_i,
    output logic       arready_o,
    output data_t      rdata_o,
    output resp_t      rresp_o,
    output logic       rvalid_o,
    input  wire logic  rready_i
);

    neuron_operands_t operands;
    neuron_result_t   result;
    result_status_t   status;
    logic             start;
    logic             clear;
    logic             result_valid;

    // register block and bus slave
    axil_reg_decode axil_reg_decode_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .awaddr_i   (awaddr_i),
        .awvalid_i  (awvalid_i),
        .awready_o  (awready_o),
        .wdata_i    (wdata_i),
        .wvalid_i   (wvalid_i),
        .wready_o   (wready_o),
        .bresp_o    (bresp_o),
        .bvalid_o   (bvalid_o),
        .bready_i   (bready_i),
        .araddr_i   (araddr_i),
        .arvalid_i  (arvalid_i),
        .arready_o  (arready_o),
        .rdata_o    (rdata_o),
        .rresp_o    (rresp_o),
        .rvalid_o   (rvalid_o),
        .rready_i   (rready_i),
        .operands_o (operands),
        .start_o    (start),
        .clear_o    (clear),
        .status_i   (status)
    );

    // neuron, started by the ctrl pulse
    output_neuron output_neuron_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .en_i           (start),
        .operands_i     (operands),
        .result_o       (result),
        .result_valid_o (result_valid)
    );

    // capture, accumulate, done flag
    loss_result loss_result_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .result_valid_i (result_valid),
        .result_i       (result),
        .start_i        (start),
        .clear_i        (clear),
        .status_o       (status)
    );

endmodule

`default_nettype wire

//--- rtl/nn_pkg.sv
`default_nettype none

package nn_pkg;

    // neuron geometry
    localparam int N_INPUTS = 8;

    // operand and result widths
    typedef logic [9:0]  act_t;
    typedef logic [7:0]  weight_t;
    typedef logic [3:0]  target_t;
    typedef logic [22:0] sum_t;
    typedef logic [45:0] loss_t;
    typedef logic [47:0] acc_t;
    typedef logic [15:0] count_t;

    // axi4-lite bus types
    typedef logic [7:0]  addr_t;
    typedef logic [31:0] data_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // register map, byte addresses
    localparam addr_t ADDR_X0      = 8'h00;
    localparam addr_t ADDR_W0      = 8'h20;
    localparam addr_t ADDR_TARGET  = 8'h40;
    localparam addr_t ADDR_CTRL    = 8'h44;
    localparam addr_t ADDR_STATUS  = 8'h48;
    localparam addr_t ADDR_SUM     = 8'h4C;
    localparam addr_t ADDR_LOSS_LO = 8'h50;
    localparam addr_t ADDR_LOSS_HI = 8'h54;
    localparam addr_t ADDR_ACC_LO  = 8'h58;
    localparam addr_t ADDR_ACC_HI  = 8'h5C;
    localparam addr_t ADDR_COUNT   = 8'h60;

    // 148 bits: x, then w, then target
    typedef struct packed {
        act_t    [N_INPUTS-1:0] x;
        weight_t [N_INPUTS-1:0] w;
        target_t                target;
    } neuron_operands_t;

    typedef struct packed {
        sum_t  sum;
        loss_t loss;
    } neuron_result_t;

    typedef struct packed {
        logic           done;
        neuron_result_t last;
        acc_t           loss_acc;
        count_t         eval_count;
    } result_status_t;

endpackage

`default_nettype wire

//--- rtl/output_neuron.sv
`timescale 1ns/10ps
`default_nettype none

module output_neuron
    import nn_pkg::*;
(
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    input  wire logic             en_i,
    input  wire neuron_operands_t operands_i,
    output neuron_result_t        result_o,
    output logic                  result_valid_o
);

    sum_t  sum_d;
    sum_t  diff_d;
    loss_t loss_d;

    // dot product, weights zero-extended
    // products and running total kept in 23 bits
    always_comb begin
        sum_d = '0;
        for (int i = 0; i < N_INPUTS; i++) begin
            sum_d = sum_d + (sum_t'(operands_i.x[i]) * sum_t'(operands_i.w[i]));
        end
    end

    // error against target
    // wraps mod 2^23 when target exceeds sum
    always_comb begin
        diff_d = sum_d - sum_t'(operands_i.target);
        loss_d = loss_t'(diff_d) * loss_t'(diff_d);
    end

    // capture on the enable edge
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            result_o <= '0;
        end else if (en_i) begin
            result_o.sum  <= sum_d;
            result_o.loss <= loss_d;
        end
    end

    // valid trails enable by one cycle
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= en_i;
        end
    end

    // start pulse comes from the register block, must be clean
    a_en_known: assert property (@(posedge clk_i) disable iff (!rst_i)
        !$isunknown(en_i));

endmodule

`default_nettype wire
